/* tb.f */
hw/me_pixel_pkg.sv
hw/me_ctrl_pkg.sv
hw/me_credit_fifo.sv
hw/me_row_counter.sv
hw/me_seq_fsm.sv
hw/me_sad_array.sv
hw/me_min_select.sv
hw/me_top.sv
verification/me_properties.sv
verification/me_tb.sv

/* verification/me_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module me_tb;
    import me_pixel_pkg::*;
    import me_ctrl_pkg::*;

    localparam int RESET_CYCLES    = 16;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 2000;

    logic       clk;
    logic       rst;
    logic       cur_valid;
    cur_row_t   cur_row;
    logic       cur_credit;
    logic       ref_valid;
    ref_row_t   ref_row;
    logic       ref_credit;
    logic       res_valid;
    me_result_t res;
    logic       res_credit;

    integer     seed;
    cur_row_t   job_cur [ME_BLK];  // Block being built by a test
    ref_row_t   job_ref [ME_BLK];
    cur_row_t   cur_tx_q [$];      // Rows waiting for a sender credit
    ref_row_t   ref_tx_q [$];
    me_result_t exp_q [$];
    me_result_t got_q [$];
    int cur_credits = ME_FIFO_DEPTH;
    int ref_credits = ME_FIFO_DEPTH;
    int cur_sent = 0;
    int ref_sent = 0;
    int cur_returned = 0;
    int ref_returned = 0;
    int pending_res_credits = 0;
    int jobs_queued = 0;
    logic hold_credits = 1'b0;     // Consumer stalls while set
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    me_top u_me_top (
        .clk       (clk),
        .rst       (rst),
        .cur_valid (cur_valid),
        .cur_row   (cur_row),
        .cur_credit(cur_credit),
        .ref_valid (ref_valid),
        .ref_row   (ref_row),
        .ref_credit(ref_credit),
        .res_valid (res_valid),
        .res       (res),
        .res_credit(res_credit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    // Current row sender, gains a credit per pulse and spends one per valid cycle
    initial begin
        forever begin
            @(posedge clk);
            if (cur_credit) begin
                cur_credits++;
                cur_returned++;
            end
            if (!rst && cur_tx_q.size() != 0 && cur_credits > 0) begin
                cur_row   <= cur_tx_q.pop_front();
                cur_valid <= 1'b1;
                cur_credits--;
                cur_sent++;
            end else begin
                cur_valid <= 1'b0;
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            if (ref_credit) begin
                ref_credits++;
                ref_returned++;
            end
            if (!rst && ref_tx_q.size() != 0 && ref_credits > 0) begin
                ref_row   <= ref_tx_q.pop_front();
                ref_valid <= 1'b1;
                ref_credits--;
                ref_sent++;
            end else begin
                ref_valid <= 1'b0;
            end
        end
    end

    // Result consumer returns one credit per absorbed result
    initial begin
        forever begin
            @(posedge clk);
            if (res_valid) begin
                got_q.push_back(res);
                pending_res_credits++;
            end
            if (!rst && !hold_credits && pending_res_credits > 0) begin
                res_credit <= 1'b1;
                pending_res_credits--;
            end else begin
                res_credit <= 1'b0;
            end
        end
    end

    function automatic pixel_t rand_pixel();
        return pixel_t'($random(seed));
    endfunction

    // Full search over the job arrays, strict less-than keeps the lowest index
    function automatic me_result_t compute_expected();
        int         sad;
        int         diff;
        int         best_sad;
        int         best_idx;
        me_result_t r;
        best_sad = -1;
        best_idx = 0;
        for (int k = 0; k < ME_CANDS; k++) begin
            sad = 0;
            for (int row = 0; row < ME_BLK; row++) begin
                for (int c = 0; c < ME_BLK; c++) begin
                    diff = int'(job_cur[row][c]) - int'(job_ref[row][c + k]);
                    sad += (diff < 0) ? -diff : diff;
                end
            end
            if (best_sad < 0 || sad < best_sad) begin
                best_sad = sad;
                best_idx = k;
            end
        end
        r.best_sad = sad_t'(best_sad);
        r.best_idx = cand_idx_t'(best_idx);
        return r;
    endfunction

    task automatic fill_random();
        for (int row = 0; row < ME_BLK; row++) begin
            for (int c = 0; c < ME_REF_W; c++) job_ref[row][c] = rand_pixel();
            for (int c = 0; c < ME_BLK; c++) job_cur[row][c] = rand_pixel();
        end
    endtask

    task automatic fill_exact(input int k);
        fill_random();
        for (int row = 0; row < ME_BLK; row++) begin
            for (int c = 0; c < ME_BLK; c++) job_cur[row][c] = job_ref[row][c + k];
        end
    endtask

    task automatic fill_flat(input pixel_t cur_pix, input pixel_t ref_pix);
        for (int row = 0; row < ME_BLK; row++) begin
            job_cur[row] = {ME_BLK{cur_pix}};
            job_ref[row] = {ME_REF_W{ref_pix}};
        end
    endtask

    task automatic queue_job(input me_result_t expected);
        for (int row = 0; row < ME_BLK; row++) begin
            cur_tx_q.push_back(job_cur[row]);
            ref_tx_q.push_back(job_ref[row]);
        end
        exp_q.push_back(expected);
        jobs_queued++;
    endtask

    task automatic check_result(input me_result_t got, input me_result_t expected,
                                input string what);
        if (got !== expected) begin
            errors++;
            $display("** Error at %0t: %s got sad %0d idx %0d, expected sad %0d idx %0d",
                     $time, what, got.best_sad, got.best_idx,
                     expected.best_sad, expected.best_idx);
        end
    endtask

    task automatic check_credits(input int got, input int expected, input string what);
        if (got != expected) begin
            errors++;
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic check_flag(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            errors++;
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, expected);
        end
    endtask

    task automatic wait_results(input int n, input string what);
        int waited;
        waited = 0;
        while (got_q.size() < n && waited < CYCLES_PER_TEST) begin
            @(negedge clk);
            waited++;
        end
        if (got_q.size() < n) begin
            errors++;
            $display("%s: only %0d of %0d results arrived in time", what, got_q.size(), n);
        end
    endtask

    task automatic drain_and_check(input int n, input string what);
        wait_results(n, what);
        while (got_q.size() != 0 && exp_q.size() != 0) begin
            check_result(got_q.pop_front(), exp_q.pop_front(), what);
        end
        got_q.delete();
        exp_q.delete();
    endtask

    // Waits until every row is sent and every credit is back with its owner
    task automatic settle(input string what);
        int waited;
        waited = 0;
        while (!(cur_tx_q.size() == 0 && ref_tx_q.size() == 0 && pending_res_credits == 0 &&
                 cur_credits == ME_FIFO_DEPTH && ref_credits == ME_FIFO_DEPTH) &&
               waited < CYCLES_PER_TEST) begin
            @(negedge clk);
            waited++;
        end
        if (waited == CYCLES_PER_TEST) begin
            errors++;
            $display("%s: credits did not return to their senders", what);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%-20s passed", name);
        end else begin
            tests_failed++;
            $display("%-20s failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic test_reset_idle();
        int err_before;
        err_before = errors;
        check_flag(res_valid, 1'b0, "res_valid after reset");
        check_flag(cur_credit, 1'b0, "cur_credit after reset");
        check_flag(ref_credit, 1'b0, "ref_credit after reset");
        repeat (50) @(negedge clk);
        check_credits(got_q.size(), 0, "results with no rows sent");
        check_credits(cur_returned + ref_returned, 0, "credits with no rows sent");
        report_test("reset_idle", err_before);
    endtask

    task automatic test_exact_match();
        int         err_before;
        int         offsets [4];
        me_result_t expected;
        err_before = errors;
        offsets = '{0, 3, 9, 15};
        foreach (offsets[i]) begin
            fill_exact(offsets[i]);
            expected.best_sad = '0;
            expected.best_idx = cand_idx_t'(offsets[i]);
            queue_job(expected);
        end
        drain_and_check(4, "exact match");
        settle("exact match");
        report_test("exact_match", err_before);
    endtask

    task automatic test_ties();
        int         err_before;
        me_result_t expected;
        err_before = errors;
        expected.best_idx = '0;           // Every candidate ties
        fill_flat(8'd40, 8'd100);
        expected.best_sad = sad_t'(64 * 60);
        queue_job(expected);
        fill_flat(8'd200, 8'd200);
        expected.best_sad = '0;
        queue_job(expected);
        fill_flat(8'd10, 8'd255);
        expected.best_sad = sad_t'(64 * 245);
        queue_job(expected);
        drain_and_check(3, "ties");
        settle("ties");
        report_test("ties", err_before);
    endtask

    task automatic test_random_jobs();
        int err_before;
        err_before = errors;
        for (int j = 0; j < 5; j++) begin
            fill_random();
            queue_job(compute_expected());
        end
        drain_and_check(5, "random jobs");
        settle("random jobs");
        report_test("random_jobs", err_before);
    endtask

    task automatic test_back_pressure();
        int err_before;
        err_before = errors;
        hold_credits = 1'b1;
        for (int j = 0; j < 3; j++) begin
            fill_random();
            queue_job(compute_expected());
        end
        wait_results(ME_OUT_CREDITS, "back pressure");
        repeat (200) @(negedge clk);      // Third job must stay parked in EMIT
        check_credits(got_q.size(), ME_OUT_CREDITS, "results while credits held");
        hold_credits = 1'b0;
        drain_and_check(3, "back pressure");
        settle("back pressure");
        report_test("back_pressure", err_before);
    endtask

    task automatic test_credit_conservation();
        int err_before;
        err_before = errors;
        for (int j = 0; j < 2; j++) begin
            fill_random();
            queue_job(compute_expected());
        end
        drain_and_check(2, "conservation");
        settle("conservation");
        check_credits(cur_sent, ME_BLK * jobs_queued, "current rows sent");
        check_credits(ref_sent, ME_BLK * jobs_queued, "reference rows sent");
        check_credits(cur_returned, cur_sent, "current credits returned");
        check_credits(ref_returned, ref_sent, "reference credits returned");
        check_credits(cur_credits, ME_FIFO_DEPTH, "current sender credits");
        check_credits(ref_credits, ME_FIFO_DEPTH, "reference sender credits");
        report_test("credit_conservation", err_before);
    endtask

    initial begin
        int total;
        seed       = 32'h8344;
        rst        = 1'b1;
        cur_valid  = 1'b0;
        cur_row    = '0;
        ref_valid  = 1'b0;
        ref_row    = '0;
        res_credit = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        test_reset_idle();
        test_exact_match();
        test_ties();
        test_random_jobs();
        test_back_pressure();
        test_credit_conservation();
        total = errors + int'(u_me_top.u_me_properties.assert_fails);
        $display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, u_me_top.u_me_properties.assert_fails);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/me_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module me_properties (
    input logic clk,
    input logic rst,
    input logic cur_valid,
    input logic ref_valid,
    input logic load_cur,
    input logic accum,
    input logic cur_credit,
    input logic ref_credit,
    input logic res_valid,
    input logic res_credit
);
    import me_ctrl_pkg::*;

    int          cur_level;    // FIFO occupancy seen from the ports
    int          ref_level;
    int          cur_owed;     // Rows taken in and not yet credited back
    int          ref_owed;
    int          out_level;    // Result credits held by the engine
    int unsigned assert_fails = 0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_level <= 0;
            ref_level <= 0;
            cur_owed  <= 0;
            ref_owed  <= 0;
            out_level <= ME_OUT_CREDITS;
        end else begin
            cur_level <= cur_level + (cur_valid ? 1 : 0) - (load_cur ? 1 : 0);
            ref_level <= ref_level + (ref_valid ? 1 : 0) - (accum ? 1 : 0);
            cur_owed  <= cur_owed + (cur_valid ? 1 : 0) - (cur_credit ? 1 : 0);
            ref_owed  <= ref_owed + (ref_valid ? 1 : 0) - (ref_credit ? 1 : 0);
            out_level <= out_level - (res_valid ? 1 : 0) + (res_credit ? 1 : 0);
        end
    end

    cur_push_room: assert property (@(posedge clk) disable iff (rst)
        cur_valid |-> cur_level < ME_FIFO_DEPTH)
        else begin
            assert_fails++;
            $error("current FIFO pushed while full");
        end

    ref_push_room: assert property (@(posedge clk) disable iff (rst)
        ref_valid |-> ref_level < ME_FIFO_DEPTH)
        else begin
            assert_fails++;
            $error("reference FIFO pushed while full");
        end

    res_has_credit: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> out_level > 0)
        else begin
            assert_fails++;
            $error("result sent without an output credit");
        end

    // Each credit cycle gives back one row that was taken in earlier
    cur_credit_pulse: assert property (@(posedge clk) disable iff (rst)
        cur_credit |-> cur_owed > 0)
        else begin
            assert_fails++;
            $error("current credit returned with no row outstanding");
        end

    ref_credit_pulse: assert property (@(posedge clk) disable iff (rst)
        ref_credit |-> ref_owed > 0)
        else begin
            assert_fails++;
            $error("reference credit returned with no row outstanding");
        end

endmodule

bind me_top me_properties u_me_properties (
    .clk       (clk),
    .rst       (rst),
    .cur_valid (cur_valid),
    .ref_valid (ref_valid),
    .load_cur  (load_cur),
    .accum     (accum),
    .cur_credit(cur_credit),
    .ref_credit(ref_credit),
    .res_valid (res_valid),
    .res_credit(res_credit)
);

`default_nettype wire

/* hw/me_top.sv */
`timescale 1ns/100ps
`default_nettype none

module me_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cur_valid,
    input  me_pixel_pkg::cur_row_t   cur_row,
    output logic                     cur_credit,
    input  logic                     ref_valid,
    input  me_pixel_pkg::ref_row_t   ref_row,
    output logic                     ref_credit,
    output logic                     res_valid,
    output me_pixel_pkg::me_result_t res,
    input  logic                     res_credit
);
    import me_pixel_pkg::*;
    import me_ctrl_pkg::*;

    cur_row_t              cur_head;
    ref_row_t              ref_head;
    logic                  cur_not_empty;
    logic                  ref_not_empty;
    logic                  load_cur;
    logic                  accum;
    logic                  clear;
    logic                  emit;
    logic                  restart;
    row_cnt_t              row_cnt;
    logic                  last_row;
    sad_t [ME_CANDS-1:0]   sads;

    me_credit_fifo #(
        .payload_t(cur_row_t)
    ) u_cur_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (cur_valid),
        .push_data(cur_row),
        .pop      (load_cur),
        .head     (cur_head),
        .not_empty(cur_not_empty),
        .credit   (cur_credit)
    );

    me_credit_fifo #(
        .payload_t(ref_row_t)
    ) u_ref_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (ref_valid),
        .push_data(ref_row),
        .pop      (accum),
        .head     (ref_head),
        .not_empty(ref_not_empty),
        .credit   (ref_credit)
    );

    me_row_counter u_row_counter (
        .clk     (clk),
        .rst     (rst),
        .restart (restart),
        .step    (load_cur | accum),  // One row taken from either FIFO
        .count   (row_cnt),
        .last_row(last_row)
    );

    me_seq_fsm u_seq_fsm (
        .clk       (clk),
        .rst       (rst),
        .cur_avail (cur_not_empty),
        .ref_avail (ref_not_empty),
        .last_row  (last_row),
        .res_credit(res_credit),
        .load_cur  (load_cur),
        .accum     (accum),
        .clear     (clear),
        .emit      (emit),
        .restart   (restart)
    );

    me_sad_array u_sad_array (
        .clk     (clk),
        .rst     (rst),
        .clear   (clear),
        .load_cur(load_cur),
        .cur_row (cur_head),
        .row_idx (row_cnt),
        .accum   (accum),
        .ref_row (ref_head),
        .sads    (sads)
    );

    me_min_select u_min_select (
        .clk      (clk),
        .rst      (rst),
        .sads     (sads),
        .emit     (emit),
        .res      (res),
        .res_valid(res_valid)
    );

endmodule

`default_nettype wire

/* hw/me_min_select.sv */
`timescale 1ns/100ps
`default_nettype none

module me_min_select (
    input  logic                                           clk,
    input  logic                                           rst,
    input  me_pixel_pkg::sad_t [me_pixel_pkg::ME_CANDS-1:0] sads,
    input  logic                                           emit,
    output me_pixel_pkg::me_result_t                       res,
    output logic                                           res_valid
);
    import me_pixel_pkg::*;

    // Heap-ordered tree, leaves at ME_CANDS and up, root at 1
    me_result_t node [1:2*ME_CANDS-1];

    always_comb begin
        for (int k = 0; k < ME_CANDS; k++) begin
            node[ME_CANDS + k].best_sad = sads[k];
            node[ME_CANDS + k].best_idx = cand_idx_t'(k);
        end
        for (int i = ME_CANDS - 1; i >= 1; i--) begin
            if (node[2*i + 1].best_sad < node[2*i].best_sad) begin
                node[i] = node[2*i + 1];
            end else begin
                node[i] = node[2*i];   // Ties keep the lower index
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            res <= node[1];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= emit;          // Single-cycle strobe
        end
    end

endmodule

`default_nettype wire

/* hw/me_sad_array.sv */
`timescale 1ns/100ps
`default_nettype none

module me_sad_array (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           clear,
    input  logic                                           load_cur,
    input  me_pixel_pkg::cur_row_t                         cur_row,
    input  me_ctrl_pkg::row_cnt_t                          row_idx,
    input  logic                                           accum,
    input  me_pixel_pkg::ref_row_t                         ref_row,
    output me_pixel_pkg::sad_t [me_pixel_pkg::ME_CANDS-1:0] sads
);
    import me_pixel_pkg::*;

    cur_row_t cur_blk [ME_BLK]; // Current block, one entry per row
    cur_row_t cur_sel;
    sad_t     row_sad [ME_CANDS];

    function automatic pixel_t abs_diff(input pixel_t a, input pixel_t b);
        return (a > b) ? pixel_t'(a - b) : pixel_t'(b - a);
    endfunction

    always_ff @(posedge clk) begin
        if (load_cur) begin
            cur_blk[row_idx] <= cur_row;
        end
    end

    // Row matching the incoming reference row
    assign cur_sel = cur_blk[row_idx];

    // Candidate k shifts the block k pixels right in the window
    always_comb begin
        for (int k = 0; k < ME_CANDS; k++) begin
            row_sad[k] = '0;
            for (int c = 0; c < ME_BLK; c++) begin
                row_sad[k] = row_sad[k] + sad_t'(abs_diff(cur_sel[c], ref_row[c + k]));
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sads <= '0;
        end else if (clear) begin
            sads <= '0;
        end else if (accum) begin
            for (int k = 0; k < ME_CANDS; k++) begin
                sads[k] <= sads[k] + row_sad[k]; // No overflow, 8 rows of 2040 max
            end
        end
    end

endmodule

`default_nettype wire

/* hw/me_seq_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module me_seq_fsm (
    input  logic clk,
    input  logic rst,
    input  logic cur_avail,
    input  logic ref_avail,
    input  logic last_row,
    input  logic res_credit,
    output logic load_cur,
    output logic accum,
    output logic clear,
    output logic emit,
    output logic restart
);
    import me_ctrl_pkg::*;

    me_state_t                state;
    me_state_t                state_nxt;
    logic [ME_OUT_CRED_W-1:0] out_credits;

    assign load_cur = (state == LOAD_CUR) && cur_avail; // Pops the current FIFO
    assign accum    = (state == ACCUM) && ref_avail;    // Pops the reference FIFO
    assign clear    = (state == IDLE) && cur_avail;     // Job start
    assign restart  = clear || ((load_cur || accum) && last_row);

    always_comb begin
        state_nxt = state;
        unique case (state)
            IDLE: begin
                if (cur_avail) begin
                    state_nxt = LOAD_CUR;
                end
            end
            LOAD_CUR: begin
                if (load_cur && last_row) begin
                    state_nxt = ACCUM;
                end
            end
            ACCUM: begin
                if (accum && last_row) begin
                    state_nxt = EMIT;
                end
            end
            EMIT: begin
                if (emit) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // A result leaves only while the consumer has room for it
    assign emit = (state == EMIT) && (out_credits != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_credits <= ME_OUT_CRED_W'(ME_OUT_CREDITS);
        end else begin
            unique case ({emit, res_credit})
                2'b10:   out_credits <= out_credits - 1'b1; // Spent on a result
                2'b01:   out_credits <= out_credits + 1'b1; // Returned by consumer
                default: out_credits <= out_credits;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/me_row_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module me_row_counter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  restart,
    input  logic                  step,
    output me_ctrl_pkg::row_cnt_t count,
    output logic                  last_row
);
    import me_ctrl_pkg::*;
    import me_pixel_pkg::*;

    assign last_row = (count == row_cnt_t'(ME_BLK - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (restart) begin
            count <= '0;               // New phase starts at row 0
        end else if (step) begin
            count <= count + 1'b1;     // Wraps to 0 after row 7
        end
    end

endmodule

`default_nettype wire

/* hw/me_credit_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module me_credit_fifo #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty,
    output logic     credit
);
    import me_ctrl_pkg::*;

    payload_t                 mem [ME_FIFO_DEPTH];
    logic [ME_FIFO_PTR_W-1:0] wr_ptr;
    logic [ME_FIFO_PTR_W-1:0] rd_ptr;
    logic [ME_FIFO_CNT_W-1:0] count;
    logic                     full;
    logic                     do_push;
    logic                     do_pop;

    assign full      = (count == ME_FIFO_CNT_W'(ME_FIFO_DEPTH));
    assign not_empty = (count != '0);
    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;
    assign head      = mem[rd_ptr]; // Show-ahead head

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= do_pop; // One credit back per popped entry
            if (do_push) begin
                wr_ptr <= (wr_ptr == ME_FIFO_PTR_W'(ME_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ME_FIFO_PTR_W'(ME_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            unique case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/me_ctrl_pkg.sv */
`default_nettype none

package me_ctrl_pkg;

    localparam int ME_FIFO_DEPTH  = 8; // Also the sender credits after reset
    localparam int ME_OUT_CREDITS = 2; // Result credits after reset

    localparam int ME_FIFO_PTR_W = $clog2(ME_FIFO_DEPTH);
    localparam int ME_FIFO_CNT_W = $clog2(ME_FIFO_DEPTH + 1);
    localparam int ME_OUT_CRED_W = $clog2(ME_OUT_CREDITS + 1);

    typedef enum logic [1:0] {
        IDLE     = 2'd0, // Waiting for a current block
        LOAD_CUR = 2'd1, // Storing the 8 current rows
        ACCUM    = 2'd2, // One reference row per step
        EMIT     = 2'd3  // Waiting for a result credit
    } me_state_t;

    typedef logic [2:0] row_cnt_t;

endpackage

`default_nettype wire

/* hw/me_pixel_pkg.sv */
`default_nettype none

package me_pixel_pkg;

    localparam int ME_BLK   = 8;                     // Block edge in pixels
    localparam int ME_CANDS = 16;                    // Candidate positions per search row
    localparam int ME_REF_W = ME_BLK + ME_CANDS - 1; // Reference row width
    localparam int ME_PIX_W = 8;
    localparam int ME_SAD_W = 14;                    // Holds 64 x 255

    typedef logic [ME_PIX_W-1:0] pixel_t;

    // Element 0 is the leftmost pixel of a row
    typedef pixel_t [ME_BLK-1:0]   cur_row_t;
    typedef pixel_t [ME_REF_W-1:0] ref_row_t;

    typedef logic [ME_SAD_W-1:0]         sad_t;
    typedef logic [$clog2(ME_CANDS)-1:0] cand_idx_t;

    typedef struct packed {
        sad_t      best_sad;
        cand_idx_t best_idx;
    } me_result_t;

endpackage

`default_nettype wire
